// File: dpmem_trace.txt
// columns: port type addr len data expected_data check
// type 0 rd 1 wr 2 add 3 and 4 or; len 0 word 1 byte 2 half; check 0 skips data
// port 0, words at 0x000
0 1 0000 0 0a0b0c0d 00000000 0
0 1 0000 0 11223344 0a0b0c0d 1
0 0 0000 0 00000000 11223344 1
0 1 0004 0 0a0b0c0d 00000000 0
0 1 0004 1 000000ef 0000000d 1
0 0 0004 1 00000000 000000ef 1
0 0 0005 1 00000000 0000000c 1
0 0 0006 1 00000000 0000000b 1
0 0 0007 1 00000000 0000000a 1
0 1 0006 2 00005566 00000a0b 1
0 0 0004 0 00000000 55660cef 1
0 0 0004 2 00000000 00000cef 1
0 1 0008 0 12345678 00000000 0
0 2 0008 0 87654321 12345678 1
0 3 0008 0 ff00ff00 99999999 1
0 4 0008 0 00be00ef 99009900 1
0 0 0008 0 00000000 99be99ef 1
// port 1, words at 0x200
1 1 0200 0 deadbeef 00000000 0
1 1 0200 0 cafef00d deadbeef 1
1 0 0200 0 00000000 cafef00d 1
1 1 0203 1 000000a5 000000ca 1
1 0 0200 0 00000000 a5fef00d 1
1 1 0200 2 00001234 0000f00d 1
1 0 0202 2 00000000 0000a5fe 1
1 0 0200 0 00000000 a5fe1234 1
1 1 0204 0 00000010 00000000 0
1 2 0204 0 00000005 00000010 1
1 4 0204 0 00000100 00000015 1
1 3 0204 0 0000010f 00000115 1
1 0 0204 0 00000000 00000105 1
1 0 0201 1 00000000 00000012 1
// end of trace
f 0 0000 0 00000000 00000000 0

// File: verilog.f
mem_cfg_pkg.sv
mem_msg_pkg.sv
mem_port_ctrl.sv
mem_bank.sv
dpmem_top.sv
tb_dpmem.sv

// File: run_sim.sh
#!/bin/sh
# build and run tb_dpmem with Verilator from the project root

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_dpmem \
  -f verilog.f -o tb_dpmem_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/tb_dpmem_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "^Verification passed$" sim.log; then
  exit 0
else
  echo "pass message not found in sim.log"
  exit 1
fi

// File: tb_dpmem.sv
/* trace-driven testbench of the dual-port memory; records come from
   dpmem_trace.txt, one stream per port, ended by a record with port f */

`timescale 1ns/1ps

// ----------------------------------------------------------------------
// one port: request driver, resp_rdy toggling and response checks
// ----------------------------------------------------------------------

module port_agent
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int port_id     = 0,
  parameter int trace_words = 7
)(
  input  logic        clk,
  input  logic        rst_n,
  input  logic [31:0] trace_mem [trace_words],
  input  int          rec_count,

  output logic        req_val,
  input  logic        req_rdy,
  output mem_req_t    req_msg,
  input  logic        resp_val,
  output logic        resp_rdy,
  input  mem_resp_t   resp_msg,

  output int          err_count,
  output logic        done
);

  localparam int rec_cols = 7;  // port type addr len data exp chk

  mem_req_t  req_q [$];
  mem_resp_t exp_q [$];
  logic      chk_q [$];  // 0 when the old word is not known
  int        n_exp;
  int        n_seen;
  int        drv_seed;
  int        rdy_seed;
  logic      held;
  mem_resp_t held_msg;

  task automatic load_stream();
    int        base;
    mem_req_t  req;
    mem_resp_t exp;
    for (int i = 0; i < rec_count; i++)
    begin
      base = i * rec_cols;
      if (trace_mem[base] == port_id)
      begin
        req.msg_type = mem_type_e'(trace_mem[base+1][2:0]);
        req.addr     = trace_mem[base+2][addr_w-1:0];
        req.len      = trace_mem[base+3][1:0];
        req.data     = trace_mem[base+4];
        exp.msg_type = req.msg_type;  // type and len come back echoed
        exp.len      = req.len;
        exp.data     = trace_mem[base+5];
        req_q.push_back(req);
        exp_q.push_back(exp);
        chk_q.push_back(trace_mem[base+6][0]);
      end
    end
    n_exp = exp_q.size();
  endtask

  task automatic send_requests();
    int gap;
    @(posedge clk);
    #1;
    for (int k = 0; k < req_q.size(); k++)
    begin
      gap = $random(drv_seed) & 32'h3;
      repeat (gap)
      begin
        @(posedge clk);
        #1;
      end
      req_val = 1'b1;
      req_msg = req_q[k];
      @(negedge clk);
      while (!req_rdy)
        @(negedge clk);
      @(posedge clk);  // handshake edge
      #1;
      req_val = 1'b0;
      req_msg = '0;
    end
  endtask

  task automatic drive_resp_rdy();
    forever
    begin
      @(posedge clk);
      #1 resp_rdy = ($random(rdy_seed) & 32'h3) != 0;  // low about a quarter of cycles
    end
  endtask

  task automatic check_response();
    mem_resp_t exp;
    logic      chk;
    assert (exp_q.size() != 0)
    else
    begin
      err_count++;
      $display("port %0d returned a response with no request outstanding", port_id);
    end
    if (exp_q.size() != 0)
    begin
      exp = exp_q.pop_front();
      chk = chk_q.pop_front();
      assert (resp_msg.msg_type == exp.msg_type && resp_msg.len == exp.len
              && (!chk || resp_msg.data == exp.data))
      else
      begin
        err_count++;
        // values shown as type/len/data
        $display("Error at %0t: port %0d response %0d expected %0d/%0d/%08h, got %0d/%0d/%08h",
                 $time, port_id, n_seen, exp.msg_type, exp.len, exp.data,
                 resp_msg.msg_type, resp_msg.len, resp_msg.data);
      end
      n_seen++;
      if (n_seen == n_exp)
        done = 1'b1;
    end
  endtask

  // sampled mid-cycle, where everything seen by the next edge is settled
  task automatic watch_responses();
    forever
    begin
      @(negedge clk);
      if (held)
      begin
        assert (resp_val)
        else
        begin
          err_count++;
          $display("port %0d withdrew a response before it was taken", port_id);
        end
        if (resp_val)
        begin
          assert (resp_msg == held_msg)
          else
          begin
            err_count++;
            $display("Error at %0t: port %0d response changed under back-pressure, held %h, now %h",
                     $time, port_id, held_msg, resp_msg);
          end
        end
      end
      held = 1'b0;
      if (resp_val)
      begin
        assert (!req_rdy)
        else
        begin
          err_count++;
          $display("Error at %0t: port %0d req_rdy high while a response is pending",
                   $time, port_id);
        end
        if (resp_rdy)
          check_response();
        else
        begin
          held     = 1'b1;
          held_msg = resp_msg;
        end
      end
    end
  endtask

  initial
  begin
    req_val   = 1'b0;
    req_msg   = '0;
    resp_rdy  = 1'b0;
    err_count = 0;
    done      = 1'b0;
    held      = 1'b0;
    held_msg  = '0;
    n_seen    = 0;
    n_exp     = 0;
    drv_seed  = 32'hcf0e_c296;
    rdy_seed  = 32'hcf0e_c296;
    wait (rst_n === 1'b1);  // trace is loaded by then
    load_stream();
    if (n_exp == 0)
      done = 1'b1;
    fork
      send_requests();
      drive_resp_rdy();
      watch_responses();
    join
  end

endmodule

// ----------------------------------------------------------------------
// top: clock, reset, trace load, watchdog and final verdict
// ----------------------------------------------------------------------

module tb_dpmem
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
();

  localparam int rec_cols       = 7;
  localparam int trace_max      = 64;
  localparam int trace_words    = trace_max * rec_cols;
  localparam int cycles_per_rec = 40;

  logic        clk = 1'b0;
  logic        rst_n;
  logic [31:0] trace_mem [trace_words];
  int          rec_count;
  logic        loaded;
  int          reset_errs;

  logic      req_val [2];
  logic      req_rdy [2];
  mem_req_t  req_msg [2];
  logic      resp_val [2];
  logic      resp_rdy [2];
  mem_resp_t resp_msg [2];
  int        err_count [2];
  logic      done [2];

  always #50 clk = ~clk;  // 100 ns period

  dpmem_top #(.mem_words(mem_bytes / byte_lanes)) i_dpmem_top
  (
    .clk        (clk),
    .rst_n      (rst_n),
    .req_0_val  (req_val[0]),
    .req_0_rdy  (req_rdy[0]),
    .req_0_msg  (req_msg[0]),
    .resp_0_val (resp_val[0]),
    .resp_0_rdy (resp_rdy[0]),
    .resp_0_msg (resp_msg[0]),
    .req_1_val  (req_val[1]),
    .req_1_rdy  (req_rdy[1]),
    .req_1_msg  (req_msg[1]),
    .resp_1_val (resp_val[1]),
    .resp_1_rdy (resp_rdy[1]),
    .resp_1_msg (resp_msg[1])
  );

  for (genvar p = 0; p < 2; p++)
  begin : g_agent
    port_agent #(.port_id(p), .trace_words(trace_words)) agent
    (
      .clk       (clk),
      .rst_n     (rst_n),
      .trace_mem (trace_mem),
      .rec_count (rec_count),
      .req_val   (req_val[p]),
      .req_rdy   (req_rdy[p]),
      .req_msg   (req_msg[p]),
      .resp_val  (resp_val[p]),
      .resp_rdy  (resp_rdy[p]),
      .resp_msg  (resp_msg[p]),
      .err_count (err_count[p]),
      .done      (done[p])
    );
  end

  initial
  begin
    rst_n      = 1'b0;
    loaded     = 1'b0;
    reset_errs = 0;
    rec_count  = 0;
    $readmemh("dpmem_trace.txt", trace_mem);
    while (rec_count < trace_max && trace_mem[rec_count*rec_cols] != 32'hf)
      rec_count++;
    loaded = 1'b1;
    repeat (3) @(posedge clk);
    #1 rst_n = 1'b1;
    @(negedge clk);
    assert (req_rdy[0] && req_rdy[1] && !resp_val[0] && !resp_val[1])
    else
    begin
      reset_errs++;
      $display("Error at %0t: ports not idle after reset", $time);
    end
    wait (done[0] && done[1]);
    repeat (2) @(posedge clk);
    $display("error counts: port 0 %0d, port 1 %0d, reset %0d",
             err_count[0], err_count[1], reset_errs);
    if (err_count[0] + err_count[1] + reset_errs == 0)
      $display("Verification passed");
    else
      $display("Verification failed");
    $finish;
  end

  initial
  begin
    wait (loaded === 1'b1);
    repeat (rec_count * cycles_per_rec) @(posedge clk);
    $display("watchdog expired after %0d cycles, responses are missing",
             rec_count * cycles_per_rec);
    $display("Verification failed");
    $finish;
  end

endmodule

// File: dpmem_top.sv
/* dual-port test memory; each port answers its own requests in order,
   one in flight per port */

`timescale 1ns/1ps

module dpmem_top
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int mem_words = mem_bytes / byte_lanes
)(
  input  logic      clk,
  input  logic      rst_n,

  input  logic      req_0_val,
  output logic      req_0_rdy,
  input  mem_req_t  req_0_msg,
  output logic      resp_0_val,
  input  logic      resp_0_rdy,
  output mem_resp_t resp_0_msg,

  input  logic      req_1_val,
  output logic      req_1_rdy,
  input  mem_req_t  req_1_msg,
  output logic      resp_1_val,
  input  logic      resp_1_rdy,
  output mem_resp_t resp_1_msg
);

  logic        acc_0_val;
  bank_acc_t   acc_0;
  logic        grant_0;
  bank_rdata_t rdata_0;

  logic        acc_1_val;
  bank_acc_t   acc_1;
  logic        grant_1;
  bank_rdata_t rdata_1;

  mem_port_ctrl #(.mem_words(mem_words)) u_port_0
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (req_0_val),
    .req_rdy  (req_0_rdy),
    .req_msg  (req_0_msg),
    .resp_val (resp_0_val),
    .resp_rdy (resp_0_rdy),
    .resp_msg (resp_0_msg),
    .acc_val  (acc_0_val),
    .acc      (acc_0),
    .grant    (grant_0),
    .rdata    (rdata_0)
  );

  mem_port_ctrl #(.mem_words(mem_words)) u_port_1
  (
    .clk      (clk),
    .rst_n    (rst_n),
    .req_val  (req_1_val),
    .req_rdy  (req_1_rdy),
    .req_msg  (req_1_msg),
    .resp_val (resp_1_val),
    .resp_rdy (resp_1_rdy),
    .resp_msg (resp_1_msg),
    .acc_val  (acc_1_val),
    .acc      (acc_1),
    .grant    (grant_1),
    .rdata    (rdata_1)
  );

  mem_bank #(.mem_words(mem_words)) u_bank
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .acc_0_val (acc_0_val),
    .acc_0     (acc_0),
    .grant_0   (grant_0),
    .rdata_0   (rdata_0),
    .acc_1_val (acc_1_val),
    .acc_1     (acc_1),
    .grant_1   (grant_1),
    .rdata_1   (rdata_1)
  );

endmodule

// File: mem_bank.sv
/* shared word array behind both ports; one access per cycle, picked
   round-robin, read combinationally and updated at the clock edge;
   mem_words must be a power of two no larger than mem_bytes/byte_lanes */

`timescale 1ns/1ps

module mem_bank
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int mem_words = 256
)(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        acc_0_val,
  input  bank_acc_t   acc_0,
  output logic        grant_0,
  output bank_rdata_t rdata_0,

  input  logic        acc_1_val,
  input  bank_acc_t   acc_1,
  output logic        grant_1,
  output bank_rdata_t rdata_1
);

  localparam int idx_w = $clog2(mem_words);

  logic [data_w-1:0] mem_q [mem_words];

  logic              prio_q;   // port that wins a tie
  bank_acc_t         sel_acc;
  logic [idx_w-1:0]  sel_idx;
  logic [data_w-1:0] old_word;
  logic [data_w-1:0] new_word;

  // ----------------------------------------------------------------------
  // round-robin arbitration
  // ----------------------------------------------------------------------

  assign grant_0 = acc_0_val && (!acc_1_val || !prio_q);
  assign grant_1 = acc_1_val && (!acc_0_val || prio_q);

  always_ff @(posedge clk)
  begin
    if (!rst_n)
      prio_q <= 1'b0;
    else if (grant_0)
      prio_q <= 1'b1;  // hand the tie to the other port
    else if (grant_1)
      prio_q <= 1'b0;
  end

  // ----------------------------------------------------------------------
  // array read and update
  // ----------------------------------------------------------------------

  assign sel_acc  = grant_1 ? acc_1 : acc_0;
  assign sel_idx  = sel_acc.idx[idx_w-1:0];
  assign old_word = mem_q[sel_idx];

  // both ports see the old word; only the granted one uses it
  assign rdata_0 = old_word;
  assign rdata_1 = old_word;

  always_comb
  begin
    new_word = old_word;
    case (sel_acc.op)
      mem_write:
      begin
        for (int b = 0; b < byte_lanes; b++)
        begin
          if (sel_acc.mask[b])
            new_word[b*8 +: 8] = sel_acc.wdata[b*8 +: 8];
        end
      end
      mem_amo_add: new_word = old_word + sel_acc.wdata;
      mem_amo_and: new_word = old_word & sel_acc.wdata;
      mem_amo_or:  new_word = old_word | sel_acc.wdata;
      default:     new_word = old_word;  // read
    endcase
  end

  always_ff @(posedge clk)
  begin
    if (grant_0 || grant_1)
      mem_q[sel_idx] <= new_word;
  end

  // ----------------------------------------------------------------------
  // arbitration checks
  // ----------------------------------------------------------------------

  a_one_grant : assert property (@(posedge clk) disable iff (!rst_n)
    !(grant_0 && grant_1))
    else $error("both ports granted");

  // a port that loses a tie holds its access and wins the next cycle
  a_fair_0 : assert property (@(posedge clk) disable iff (!rst_n)
    acc_0_val && grant_1 |=> grant_0)
    else $error("port 0 starved");

  a_fair_1 : assert property (@(posedge clk) disable iff (!rst_n)
    acc_1_val && grant_0 |=> grant_1)
    else $error("port 1 starved");

endmodule

// File: mem_port_ctrl.sv
/* one request port: holds a single request until the bank grants it,
   then holds the response until it is taken; accesses must be aligned
   and atomics word-length, both checked by assertions */

`timescale 1ns/1ps

module mem_port_ctrl
  import mem_cfg_pkg::*;
  import mem_msg_pkg::*;
#(
  parameter int mem_words = 256
)(
  input  logic        clk,
  input  logic        rst_n,

  input  logic        req_val,
  output logic        req_rdy,
  input  mem_req_t    req_msg,

  output logic        resp_val,
  input  logic        resp_rdy,
  output mem_resp_t   resp_msg,

  output logic        acc_val,
  output bank_acc_t   acc,
  input  logic        grant,
  input  bank_rdata_t rdata
);

  mem_req_t              req_q;
  logic                  busy_q;      // request waiting for the bank
  logic                  resp_val_q;
  mem_resp_t             resp_q;

  logic                  req_fire;
  logic [off_w+2:0]      shamt;       // byte offset in bits
  logic [byte_lanes-1:0] lane_mask;
  bank_rdata_t           rd_shift;
  logic [data_w-1:0]     resp_data;

  assign req_rdy  = !busy_q && !resp_val_q;
  assign req_fire = req_val && req_rdy;

  // ----------------------------------------------------------------------
  // request capture and response holding
  // ----------------------------------------------------------------------

  always_ff @(posedge clk)
  begin
    if (!rst_n)
    begin
      busy_q     <= 1'b0;
      resp_val_q <= 1'b0;
    end
    else
    begin
      if (req_fire)
        busy_q <= 1'b1;
      else if (busy_q && grant)
        busy_q <= 1'b0;

      if (busy_q && grant)
        resp_val_q <= 1'b1;
      else if (resp_val_q && resp_rdy)
        resp_val_q <= 1'b0;
    end
  end

  always_ff @(posedge clk)
  begin
    if (req_fire)
      req_q <= req_msg;
    if (busy_q && grant)
      resp_q <= '{msg_type: req_q.msg_type, len: req_q.len, data: resp_data};
  end

  // ----------------------------------------------------------------------
  // lane alignment
  // ----------------------------------------------------------------------

  assign shamt = {req_q.addr[off_w-1:0], 3'b000};

  always_comb
  begin
    case (req_q.len)
      len_byte: lane_mask = {{(byte_lanes-1){1'b0}}, 1'b1} << req_q.addr[off_w-1:0];
      len_half: lane_mask = {{(byte_lanes-2){1'b0}}, 2'b11} << req_q.addr[off_w-1:0];
      default:  lane_mask = '1;  // full word
    endcase
  end

  assign acc_val   = busy_q;
  assign acc.op    = req_q.msg_type;
  assign acc.idx   = req_q.addr[off_w +: word_idx_w];
  assign acc.mask  = lane_mask;
  assign acc.wdata = req_q.data << shamt;

  // old word back down to lane 0, zero-extended
  assign rd_shift = rdata >> shamt;

  always_comb
  begin
    case (req_q.len)
      len_byte: resp_data = {{(data_w-8){1'b0}}, rd_shift[7:0]};
      len_half: resp_data = {{(data_w-16){1'b0}}, rd_shift[15:0]};
      default:  resp_data = rd_shift;
    endcase
  end

  assign resp_val = resp_val_q;
  assign resp_msg = resp_q;

  // ----------------------------------------------------------------------
  // request legality, checked at acceptance
  // ----------------------------------------------------------------------

  a_len_legal : assert property (@(posedge clk) disable iff (!rst_n)
    req_fire |-> req_msg.len != 2'd3)
    else $error("illegal access length");

  a_aligned : assert property (@(posedge clk) disable iff (!rst_n)
    req_fire |-> (req_msg.len == len_half) ? !req_msg.addr[0] :
                 (req_msg.len == len_word) ? req_msg.addr[off_w-1:0] == '0 : 1'b1)
    else $error("unaligned access");

  a_in_range : assert property (@(posedge clk) disable iff (!rst_n)
    req_fire |-> req_msg.addr[addr_w-1:off_w] < mem_words)
    else $error("address outside memory");

  a_amo_word : assert property (@(posedge clk) disable iff (!rst_n)
    req_fire && req_msg.msg_type inside {mem_amo_add, mem_amo_and, mem_amo_or}
      |-> req_msg.len == len_word)
    else $error("atomic access not word-length");

endmodule

// File: mem_msg_pkg.sv
/* message formats of the request/response channels and of the port to
   bank access; the word index is sized for mem_bytes, so a smaller
   memory uses only its low bits */

package mem_msg_pkg;

  import mem_cfg_pkg::*;

  // ----------------------------------------------------------------------
  // channel messages
  // ----------------------------------------------------------------------

  typedef enum logic [2:0]
  {
    mem_read    = 3'd0,
    mem_write   = 3'd1,
    mem_amo_add = 3'd2,
    mem_amo_and = 3'd3,
    mem_amo_or  = 3'd4
  } mem_type_e;

  typedef logic [1:0] mem_len_t;

  localparam mem_len_t len_word = 2'd0;
  localparam mem_len_t len_byte = 2'd1;
  localparam mem_len_t len_half = 2'd2;  // 3 is not a legal length

  typedef struct packed
  {
    mem_type_e           msg_type;
    logic [addr_w-1:0]   addr;
    mem_len_t            len;
    logic [data_w-1:0]   data;
  } mem_req_t;  // 53 bits at default sizes

  typedef struct packed
  {
    mem_type_e           msg_type;
    mem_len_t            len;
    logic [data_w-1:0]   data;
  } mem_resp_t;  // 37 bits

  // ----------------------------------------------------------------------
  // port controller to bank
  // ----------------------------------------------------------------------

  localparam int word_idx_w = $clog2(mem_bytes / byte_lanes);

  typedef struct packed
  {
    mem_type_e             op;
    logic [word_idx_w-1:0] idx;    // word index
    logic [byte_lanes-1:0] mask;   // lanes touched by a write
    logic [data_w-1:0]     wdata;  // already shifted to its lanes
  } bank_acc_t;

  typedef logic [data_w-1:0] bank_rdata_t;

endpackage

// File: mem_cfg_pkg.sv
/* sizing of the dual-port test memory; data_w must be a multiple of 8
   and mem_bytes a power of two no larger than the address range */

package mem_cfg_pkg;

  // ----------------------------------------------------------------------
  // request address and data word
  // ----------------------------------------------------------------------

  parameter int addr_w = 16;  // byte address
  parameter int data_w = 32;

  // ----------------------------------------------------------------------
  // memory organisation
  // ----------------------------------------------------------------------

  parameter int mem_bytes  = 1024;
  parameter int byte_lanes = data_w / 8;

  // byte offset bits inside one word
  parameter int off_w = $clog2(byte_lanes);

endpackage
